/* Bender.yml */
package:
  name: gat_score

export_include_dirs:
  - hw

sources:
  - hw/gat_mem_pkg.sv
  - hw/gat_calc_pkg.sv
  - hw/weight_loader.sv
  - hw/spmm_row_engine.sv
  - hw/dmvm_score.sv
  - hw/score_queue.sv
  - hw/gat_score.sv
  - target: test
    files:
      - tests/gat_score_asserts.sv
      - tests/tb_gat_score.sv

/* gat_score.f */
+incdir+hw
hw/gat_mem_pkg.sv
hw/gat_calc_pkg.sv
hw/weight_loader.sv
hw/spmm_row_engine.sv
hw/dmvm_score.sv
hw/score_queue.sv
hw/gat_score.sv
tests/gat_score_asserts.sv
tests/tb_gat_score.sv

/* hw/dmvm_score.sv */
`timescale 1ns/100ps
`include "gat_score_consts.svh"

module dmvm_score (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  gat_calc_pkg::wgt_t [2*`GAT_FEAT_OUT-1:0]    a_i,
  input  logic                                        wh_valid_i,
  input  gat_calc_pkg::wh_row_t                       wh_i,
  input  logic [`GAT_Q_CNT_W-1:0]                     free_cnt_i,
  output logic                                        accept_o,
  output logic                                        pipe_idle_o,
  output logic                                        push_o,
  output gat_calc_pkg::score_pair_t                   pair_o
);

  import gat_calc_pkg::*;

  localparam int PROD_W = `GAT_DATA_W + `GAT_WH_W;

  logic signed [PROD_W-1:0]   prod_q [2*`GAT_FEAT_OUT];
  logic                       s1_vld_q;
  logic                       s2_vld_q;
  logic [1:0]                 inflight;
  score_t                     src_sum;
  score_t                     dst_sum;
  score_pair_t                pair_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld_q <= 1'b0;
      s2_vld_q <= 1'b0;
    end else begin
      s1_vld_q <= wh_valid_i;
      s2_vld_q <= s1_vld_q;
    end
  end

  // Stage one multiplies a[j] by Wh[j mod FEAT_OUT]
  always_ff @(posedge clk) begin
    if (wh_valid_i) begin
      for (int j = 0; j < 2 * `GAT_FEAT_OUT; j++) begin
        prod_q[j] <= a_i[j] * wh_i[j % `GAT_FEAT_OUT];
      end
    end
  end

  // Lower half of a scores the source, upper half the destination
  always_comb begin
    src_sum = '0;
    dst_sum = '0;
    for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
      src_sum = src_sum + prod_q[k];
      dst_sum = dst_sum + prod_q[k + `GAT_FEAT_OUT];
    end
  end

  always_ff @(posedge clk) begin
    if (s1_vld_q) begin
      pair_q <= {src_sum, dst_sum};
    end
  end

  assign inflight    = {1'b0, s1_vld_q} + {1'b0, s2_vld_q};
  assign accept_o    = (free_cnt_i > inflight);
  assign pipe_idle_o = !s1_vld_q && !s2_vld_q;
  assign push_o      = s2_vld_q;
  assign pair_o      = pair_q;

endmodule

/* hw/gat_calc_pkg.sv */
`include "gat_score_consts.svh"

package gat_calc_pkg;

  // Weight, attention and feature values share this width
  typedef logic signed [`GAT_DATA_W-1:0] wgt_t;

  typedef logic signed [`GAT_WH_W-1:0] wh_elem_t;

  // Element k sits in slice k
  typedef wh_elem_t [`GAT_FEAT_OUT-1:0] wh_row_t;

  typedef logic signed [`GAT_SCORE_W-1:0] score_t;

  // [1] source score, [0] destination score
  typedef score_t [1:0] score_pair_t;

endpackage

/* hw/gat_mem_pkg.sv */
`include "gat_score_consts.svh"

package gat_mem_pkg;

  // Column index of a nonzero, low bits of a sparse word
  localparam int COL_W = $clog2(`GAT_FEAT_IN);
  localparam int H_WORD_W = `GAT_DATA_W + COL_W;

  // Signed value in the high bits, column in the low bits
  typedef logic [H_WORD_W-1:0] h_word_t;

  typedef logic [$clog2(`GAT_H_DEPTH)-1:0] h_addr_t;

  // Row length of one node; rows are packed back to back from address 0
  typedef logic [`GAT_ROW_LEN_W-1:0] node_info_t;

  typedef logic [$clog2(`GAT_NUM_NODES)-1:0] node_idx_t;

  typedef logic [$clog2(`GAT_WGT_DEPTH)-1:0] wgt_addr_t;

endpackage

/* hw/gat_score.sv */
`timescale 1ns/100ps
`include "gat_score_consts.svh"

module gat_score (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start_req_i,
  output logic                          start_ack_o,
  output gat_mem_pkg::node_idx_t        node_info_addr_o,
  input  gat_mem_pkg::node_info_t       node_info_i,
  output gat_mem_pkg::h_addr_t          h_addr_o,
  input  gat_mem_pkg::h_word_t          h_i,
  output gat_mem_pkg::wgt_addr_t        wgt_addr_o,
  input  gat_calc_pkg::wgt_t            wgt_i,
  output logic                          wh_we_o,
  output gat_mem_pkg::node_idx_t        wh_addr_o,
  output gat_calc_pkg::wh_row_t         wh_data_o,
  output logic                          score_req_o,
  input  logic                          score_ack_i,
  output gat_calc_pkg::score_pair_t     score_o
);

  import gat_calc_pkg::*;

  logic                                       load;
  logic                                       w_ready;
  wgt_t [`GAT_FEAT_IN*`GAT_FEAT_OUT-1:0]      w;
  wgt_t [2*`GAT_FEAT_OUT-1:0]                 a;
  logic                                       accept;
  logic                                       pipe_idle;
  logic                                       wh_valid;
  logic                                       push;
  score_pair_t                                pair;
  logic [`GAT_Q_CNT_W-1:0]                    free_cnt;

  weight_loader u_weight_loader (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_i     (load),
    .wgt_addr_o (wgt_addr_o),
    .wgt_i      (wgt_i),
    .w_ready_o  (w_ready),
    .w_o        (w),
    .a_o        (a)
  );

  spmm_row_engine u_spmm_row_engine (
    .clk              (clk),
    .rst_n            (rst_n),
    .start_req_i      (start_req_i),
    .start_ack_o      (start_ack_o),
    .load_o           (load),
    .w_ready_i        (w_ready),
    .w_i              (w),
    .node_info_addr_o (node_info_addr_o),
    .node_info_i      (node_info_i),
    .h_addr_o         (h_addr_o),
    .h_i              (h_i),
    .accept_i         (accept),
    .pipe_idle_i      (pipe_idle),
    .wh_we_o          (wh_we_o),
    .wh_addr_o        (wh_addr_o),
    .wh_data_o        (wh_data_o),
    .wh_valid_o       (wh_valid)
  );

  dmvm_score u_dmvm_score (
    .clk         (clk),
    .rst_n       (rst_n),
    .a_i         (a),
    .wh_valid_i  (wh_valid),
    .wh_i        (wh_data_o),
    .free_cnt_i  (free_cnt),
    .accept_o    (accept),
    .pipe_idle_o (pipe_idle),
    .push_o      (push),
    .pair_o      (pair)
  );

  score_queue #(
    .DEPTH (`GAT_Q_DEPTH)
  ) u_score_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (push),
    .pair_i      (pair),
    .free_cnt_o  (free_cnt),
    .score_req_o (score_req_o),
    .score_ack_i (score_ack_i),
    .score_o     (score_o)
  );

endmodule

/* hw/gat_score_consts.svh */
`ifndef GAT_SCORE_CONSTS_SVH
`define GAT_SCORE_CONSTS_SVH

// Graph and feature sizes
`define GAT_NUM_NODES     16
`define GAT_FEAT_IN       8
`define GAT_FEAT_OUT      4

// Datapath widths, all signed
`define GAT_DATA_W        8
`define GAT_WH_W          20
`define GAT_SCORE_W       32

// Sparse feature storage
`define GAT_H_DEPTH       128
`define GAT_ROW_LEN_W     4

// Weight memory holds W row-major, then a
// W(i, k) at i * FEAT_OUT + k, a[j] at A_BASE + j
`define GAT_A_BASE        32
`define GAT_WGT_DEPTH     40

// Score queue
`define GAT_Q_DEPTH       4
`define GAT_Q_CNT_W       ($clog2(`GAT_Q_DEPTH + 1))

`endif

/* hw/score_queue.sv */
`timescale 1ns/100ps
`include "gat_score_consts.svh"

module score_queue #(
  parameter  int DEPTH = `GAT_Q_DEPTH,
  localparam int CNT_W = $clog2(DEPTH + 1)
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        push_i,
  input  gat_calc_pkg::score_pair_t   pair_i,
  output logic [CNT_W-1:0]            free_cnt_o,
  output logic                        score_req_o,
  input  logic                        score_ack_i,
  output gat_calc_pkg::score_pair_t   score_o
);

  import gat_calc_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  localparam logic [1:0] Q_IDLE = 2'd0;
  localparam logic [1:0] Q_REQ  = 2'd1;
  localparam logic [1:0] Q_WAIT = 2'd2;

  score_pair_t          mem_q [DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [CNT_W-1:0]     count_q;
  logic [1:0]           state_q;
  logic                 empty;
  logic                 pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty       = (count_q == '0);
  assign pop         = (state_q == Q_REQ) && score_ack_i;
  assign free_cnt_o  = CNT_W'(DEPTH) - count_q;
  assign score_req_o = (state_q == Q_REQ);
  // Head entry is not overwritten while it is offered
  assign score_o     = mem_q[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= pair_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      state_q  <= Q_IDLE;
    end else begin
      if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Four-phase output, request drops with the pop
      case (state_q)
        Q_IDLE:  if (!empty) state_q <= Q_REQ;
        Q_REQ:   if (score_ack_i) state_q <= Q_WAIT;
        Q_WAIT:  if (!score_ack_i) state_q <= Q_IDLE;
        default: state_q <= Q_IDLE;
      endcase
    end
  end

endmodule

/* hw/spmm_row_engine.sv */
`timescale 1ns/100ps
`include "gat_score_consts.svh"

module spmm_row_engine (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  start_req_i,
  output logic                                                  start_ack_o,
  output logic                                                  load_o,
  input  logic                                                  w_ready_i,
  input  gat_calc_pkg::wgt_t [`GAT_FEAT_IN*`GAT_FEAT_OUT-1:0]   w_i,
  output gat_mem_pkg::node_idx_t                                node_info_addr_o,
  input  gat_mem_pkg::node_info_t                               node_info_i,
  output gat_mem_pkg::h_addr_t                                  h_addr_o,
  input  gat_mem_pkg::h_word_t                                  h_i,
  input  logic                                                  accept_i,
  input  logic                                                  pipe_idle_i,
  output logic                                                  wh_we_o,
  output gat_mem_pkg::node_idx_t                                wh_addr_o,
  output gat_calc_pkg::wh_row_t                                 wh_data_o,
  output logic                                                  wh_valid_o
);

  import gat_mem_pkg::*;
  import gat_calc_pkg::*;

  localparam logic [3:0] S_IDLE   = 4'd0;
  localparam logic [3:0] S_LOAD   = 4'd1;
  localparam logic [3:0] S_INFO   = 4'd2;
  localparam logic [3:0] S_LEN    = 4'd3;
  localparam logic [3:0] S_STREAM = 4'd4;
  localparam logic [3:0] S_DRAIN  = 4'd5;
  localparam logic [3:0] S_WRITE  = 4'd6;
  localparam logic [3:0] S_FINISH = 4'd7;
  localparam logic [3:0] S_ACK    = 4'd8;

  logic [3:0]                       state_q;
  node_idx_t                        node_q;
  h_addr_t                          h_ptr_q;
  node_info_t                       rem_q;
  logic                             h_vld_q;
  wh_row_t                          acc_q;
  logic signed [`GAT_DATA_W-1:0]    h_val;
  logic [COL_W-1:0]                 h_col;

  assign h_val = h_i[H_WORD_W-1:COL_W];
  assign h_col = h_i[COL_W-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      node_q  <= '0;
      h_ptr_q <= '0;
      rem_q   <= '0;
      h_vld_q <= 1'b0;
    end else begin
      h_vld_q <= (state_q == S_STREAM);
      case (state_q)
        S_IDLE: begin
          if (start_req_i) begin
            state_q <= S_LOAD;
            node_q  <= '0;
            h_ptr_q <= '0;
          end
        end
        S_LOAD: if (w_ready_i) state_q <= S_INFO;
        // Hold off the next node while the score queue is short of room
        S_INFO: if (accept_i) state_q <= S_LEN;
        S_LEN: begin
          rem_q   <= node_info_i;
          state_q <= (node_info_i == '0) ? S_DRAIN : S_STREAM;
        end
        S_STREAM: begin
          h_ptr_q <= h_ptr_q + 1'b1;
          rem_q   <= rem_q - 1'b1;
          if (rem_q == node_info_t'(1)) state_q <= S_DRAIN;
        end
        S_DRAIN: state_q <= S_WRITE;
        S_WRITE: begin
          node_q  <= node_q + 1'b1;
          state_q <= (node_q == node_idx_t'(`GAT_NUM_NODES - 1)) ? S_FINISH : S_INFO;
        end
        S_FINISH: if (pipe_idle_i) state_q <= S_ACK;
        S_ACK: if (!start_req_i) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // One multiply-add per output feature for each nonzero
  always_ff @(posedge clk) begin
    if (state_q == S_LEN) begin
      acc_q <= '0;
    end else if (h_vld_q) begin
      for (int k = 0; k < `GAT_FEAT_OUT; k++) begin
        acc_q[k] <= acc_q[k] + h_val * w_i[h_col * `GAT_FEAT_OUT + k];
      end
    end
  end

  assign load_o           = (state_q == S_IDLE) && start_req_i;
  assign start_ack_o      = (state_q == S_ACK);
  assign node_info_addr_o = node_q;
  assign h_addr_o         = h_ptr_q;
  assign wh_we_o          = (state_q == S_WRITE);
  assign wh_valid_o       = (state_q == S_WRITE);
  assign wh_addr_o        = node_q;
  assign wh_data_o        = acc_q;

endmodule

/* hw/weight_loader.sv */
`timescale 1ns/100ps
`include "gat_score_consts.svh"

module weight_loader (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  load_i,
  output gat_mem_pkg::wgt_addr_t                                wgt_addr_o,
  input  gat_calc_pkg::wgt_t                                    wgt_i,
  output logic                                                  w_ready_o,
  output gat_calc_pkg::wgt_t [`GAT_FEAT_IN*`GAT_FEAT_OUT-1:0]   w_o,
  output gat_calc_pkg::wgt_t [2*`GAT_FEAT_OUT-1:0]              a_o
);

  import gat_mem_pkg::*;
  import gat_calc_pkg::*;

  localparam wgt_addr_t LAST_ADDR = wgt_addr_t'(`GAT_WGT_DEPTH - 1);

  logic                           busy_q;
  wgt_addr_t                      addr_q;
  logic                           rd_vld_q;
  wgt_addr_t                      rd_addr_q;
  wgt_t [`GAT_WGT_DEPTH-1:0]      regs_q;

  assign wgt_addr_o = addr_q;

  // Sweep all weight words, one address per cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      addr_q    <= '0;
      rd_vld_q  <= 1'b0;
      w_ready_o <= 1'b0;
    end else begin
      rd_vld_q <= busy_q;
      if (load_i) begin
        busy_q    <= 1'b1;
        addr_q    <= '0;
        w_ready_o <= 1'b0;
      end else begin
        if (busy_q) begin
          if (addr_q == LAST_ADDR) begin
            busy_q <= 1'b0;
          end else begin
            addr_q <= addr_q + 1'b1;
          end
        end
        // Last word lands this cycle
        if (rd_vld_q && (rd_addr_q == LAST_ADDR)) begin
          w_ready_o <= 1'b1;
        end
      end
    end
  end

  // Read data returns one cycle after its address
  always_ff @(posedge clk) begin
    rd_addr_q <= addr_q;
    if (rd_vld_q) begin
      regs_q[rd_addr_q] <= wgt_i;
    end
  end

  assign w_o = regs_q[`GAT_A_BASE-1:0];
  assign a_o = regs_q[`GAT_WGT_DEPTH-1:`GAT_A_BASE];

endmodule

/* tests/gat_score_asserts.sv */
`timescale 1ns/100ps

module gat_score_asserts (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       start_req_i,
  input logic                       start_ack_i,
  input logic                       wh_we_i,
  input logic                       score_req_i,
  input logic                       score_ack_i,
  input gat_calc_pkg::score_pair_t  score_i
);

  int fail_cnt = 0;

  // Start handshake
  ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(start_ack_i) |-> start_req_i)
    else begin
      fail_cnt++;
      $error("start acknowledge rose without a request");
    end

  ack_held: assert property (@(posedge clk) disable iff (!rst_n)
    start_ack_i && start_req_i |=> start_ack_i)
    else begin
      fail_cnt++;
      $error("start acknowledge fell while the request was high");
    end

  ack_release: assert property (@(posedge clk) disable iff (!rst_n)
    start_ack_i && !start_req_i |=> !start_ack_i)
    else begin
      fail_cnt++;
      $error("start acknowledge did not fall after the request");
    end

  // Wh port pulses once per node inside a run
  wh_in_run: assert property (@(posedge clk) disable iff (!rst_n)
    wh_we_i |-> start_req_i && !start_ack_i && !$past(wh_we_i))
    else begin
      fail_cnt++;
      $error("Wh write outside a run or longer than one cycle");
    end

  // Score output handshake
  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    score_req_i && !score_ack_i |=> score_req_i && $stable(score_i))
    else begin
      fail_cnt++;
      $error("score request dropped or data changed before ack");
    end

  req_release: assert property (@(posedge clk) disable iff (!rst_n)
    score_req_i && score_ack_i |=> !score_req_i)
    else begin
      fail_cnt++;
      $error("score request stayed high after the acknowledge");
    end

  req_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(score_req_i) |-> !score_ack_i)
    else begin
      fail_cnt++;
      $error("score request rose before the acknowledge fell");
    end

endmodule

/* tests/tb_gat_score.sv */
`timescale 1ns/100ps
`include "gat_score_consts.svh"

module tb_gat_score;

  import gat_mem_pkg::*;
  import gat_calc_pkg::*;

  localparam int NODES      = `GAT_NUM_NODES;
  localparam int FEAT_OUT   = `GAT_FEAT_OUT;
  localparam int MAX_CYCLES = 6000;

  logic         clk;
  logic         rst_n;
  logic         start_req;
  logic         start_ack;
  node_idx_t    node_info_addr;
  node_info_t   node_info;
  h_addr_t      h_addr;
  h_word_t      h_word;
  wgt_addr_t    wgt_addr;
  wgt_t         wgt;
  logic         wh_we;
  node_idx_t    wh_addr;
  wh_row_t      wh_data;
  logic         score_req;
  logic         score_ack;
  score_pair_t  score;

  node_info_t   node_mem [NODES];
  h_word_t      h_mem [`GAT_H_DEPTH];
  wgt_t         wgt_mem [`GAT_WGT_DEPTH];
  int           exp_wh [NODES][FEAT_OUT];
  int           exp_src [NODES];
  int           exp_dst [NODES];

  logic [31:0]  lcg_state = 32'h4a16_f64f;
  bit           slow_sink;
  int           wh_cnt;
  int           pair_cnt;
  int           err_cnt;
  int           test_cnt;
  int           failed_tests;
  int           cyc_cnt;
  int           last_wh_cyc;
  int           stall_cnt;

  gat_score dut_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .start_req_i      (start_req),
    .start_ack_o      (start_ack),
    .node_info_addr_o (node_info_addr),
    .node_info_i      (node_info),
    .h_addr_o         (h_addr),
    .h_i              (h_word),
    .wgt_addr_o       (wgt_addr),
    .wgt_i            (wgt),
    .wh_we_o          (wh_we),
    .wh_addr_o        (wh_addr),
    .wh_data_o        (wh_data),
    .score_req_o      (score_req),
    .score_ack_i      (score_ack),
    .score_o          (score)
  );

  bind gat_score gat_score_asserts u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_req_i (start_req_i),
    .start_ack_i (start_ack_o),
    .wh_we_i     (wh_we_o),
    .score_req_i (score_req_o),
    .score_ack_i (score_ack_i),
    .score_i     (score_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // External memories return data one cycle after the address
  always @(posedge clk) begin
    node_info <= node_mem[node_info_addr];
    h_word    <= h_mem[h_addr];
    wgt       <= wgt_mem[wgt_addr];
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {16'h0, lcg_state[31:16]};
  endfunction

  function automatic int total_errors();
    return err_cnt + dut_i.u_asserts.fail_cnt;
  endfunction

  task automatic expect_true(input bit cond, input string msg);
    assert (cond) else begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s", $time, msg);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    int errs;
    errs = total_errors() - errs_before;
    test_cnt++;
    if (errs != 0) failed_tests++;
    $display("Test %0d %s: %s, %0d errors", test_cnt, name, (errs == 0) ? "ok" : "bad", errs);
  endtask

  // New W, a and sparse rows along with the expected Wh and scores
  task automatic fill_memories();
    int   ptr;
    int   len;
    wgt_t v;
    for (int i = 0; i < `GAT_WGT_DEPTH; i++) begin
      wgt_mem[i] = wgt_t'(next_rand());
    end
    for (int i = 0; i < `GAT_H_DEPTH; i++) begin
      h_mem[i] = h_word_t'(next_rand());
    end
    ptr = 0;
    for (int n = 0; n < NODES; n++) begin
      // Node 3 always empty
      len = (n == 3) ? 0 : int'(next_rand() % 9);
      node_mem[n] = node_info_t'(len);
      exp_src[n] = 0;
      exp_dst[n] = 0;
      for (int k = 0; k < FEAT_OUT; k++) begin
        exp_wh[n][k] = 0;
      end
      // Exactly len distinct columns in ascending order
      for (int c = 0; c < `GAT_FEAT_IN; c++) begin
        if (len > 0 && int'(next_rand() % (`GAT_FEAT_IN - c)) < len) begin
          v = wgt_t'(next_rand());
          h_mem[ptr] = {v, COL_W'(c)};
          for (int k = 0; k < FEAT_OUT; k++) begin
            exp_wh[n][k] += v * wgt_mem[c * FEAT_OUT + k];
          end
          ptr++;
          len--;
        end
      end
      for (int k = 0; k < FEAT_OUT; k++) begin
        exp_src[n] += wgt_mem[`GAT_A_BASE + k] * exp_wh[n][k];
        exp_dst[n] += wgt_mem[`GAT_A_BASE + FEAT_OUT + k] * exp_wh[n][k];
      end
    end
  endtask

  always @(negedge clk) begin
    cyc_cnt++;
    if (rst_n && wh_we) begin
      expect_true(wh_cnt < NODES, "Wh write beyond the last node");
      if (wh_cnt < NODES) begin
        expect_true(wh_addr == node_idx_t'(wh_cnt),
                    $sformatf("Wh address %0d, expected %0d", wh_addr, wh_cnt));
        for (int k = 0; k < FEAT_OUT; k++) begin
          expect_true(wh_data[k] == exp_wh[wh_cnt][k],
                      $sformatf("node %0d Wh[%0d] = %0d, expected %0d",
                                wh_cnt, k, wh_data[k], exp_wh[wh_cnt][k]));
        end
        // Unstalled nodes write row length plus 4 cycles apart
        if (wh_cnt > 0 && cyc_cnt - last_wh_cyc > int'(node_mem[wh_cnt]) + 4) begin
          stall_cnt++;
        end
      end
      last_wh_cyc = cyc_cnt;
      wh_cnt++;
    end
  end

  // Four-phase score sink with random delays when slow
  initial begin : sink
    int delay;
    forever begin
      @(posedge clk);
      if (rst_n && score_req && !score_ack) begin
        expect_true(pair_cnt < NODES, "score pair beyond the last node");
        if (pair_cnt < NODES) begin
          expect_true(score[1] == exp_src[pair_cnt] && score[0] == exp_dst[pair_cnt],
                      $sformatf("node %0d scores %0d/%0d, expected %0d/%0d", pair_cnt,
                                score[1], score[0], exp_src[pair_cnt], exp_dst[pair_cnt]));
        end
        pair_cnt++;
        delay = slow_sink ? int'(next_rand() % 8) : 0;
        repeat (delay) @(posedge clk);
        score_ack <= 1'b1;
        do begin
          @(posedge clk);
        end while (score_req);
        delay = slow_sink ? int'(next_rand() % 8) : 0;
        repeat (delay) @(posedge clk);
        score_ack <= 1'b0;
      end
    end
  end

  task automatic run_layer(input string name, input bit slow);
    int errs_before;
    errs_before = total_errors();
    slow_sink = slow;
    wh_cnt    = 0;
    pair_cnt  = 0;
    stall_cnt = 0;
    @(posedge clk);
    start_req <= 1'b1;
    do begin
      @(posedge clk);
    end while (!start_ack);
    expect_true(wh_cnt == NODES, $sformatf("%0d Wh writes at the start acknowledge", wh_cnt));
    if (slow) begin
      expect_true(stall_cnt > 0, "slow score sink caused no back-pressure stall");
    end
    start_req <= 1'b0;
    do begin
      @(posedge clk);
    end while (start_ack);
    // Queued pairs drain after the acknowledge
    while (pair_cnt < NODES) @(posedge clk);
    repeat (10) @(posedge clk);
    expect_true(pair_cnt == NODES, $sformatf("%0d score pairs received", pair_cnt));
    report_test(name, errs_before);
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the run did not complete", cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin : main
    int errs_before;
    rst_n        = 1'b0;
    start_req    = 1'b0;
    score_ack    = 1'b0;
    node_info    = '0;
    h_word       = '0;
    wgt          = '0;
    err_cnt      = 0;
    test_cnt     = 0;
    failed_tests = 0;
    wh_cnt       = 0;
    pair_cnt     = 0;
    fill_memories();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    errs_before = total_errors();
    repeat (20) begin
      @(negedge clk);
      expect_true(!start_ack && !wh_we && !score_req, "output active before any start");
    end
    expect_true(wh_cnt == 0, "Wh write before any start");
    report_test("reset state", errs_before);
    run_layer("first start, fast sink", 1'b0);
    fill_memories();
    run_layer("new weights, slow sink", 1'b1);
    fill_memories();
    run_layer("third start, reload", 1'b0);
    $display("Summary: %0d tests, %0d with errors, %0d errors in all",
             test_cnt, failed_tests, total_errors());
    if (total_errors() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
